// File: sim/dcache_cases.txt
// first word is the case count, then one case per line
// op(0 load 1 store) size(0 b 1 h 2 w) unsigned address wdata expected_rdata
0000001a
0 2 0 00000100 00000000 fffffeff
0 2 0 00000104 00000000 fffffefb
0 2 0 0000010c 00000000 fffffef3
0 0 0 00000108 00000000 fffffff7
0 0 1 00000108 00000000 000000f7
0 0 0 80000120 00000000 ffffffdf
0 0 1 80000120 00000000 000000df
0 0 0 80000121 00000000 fffffffe
0 0 1 80000122 00000000 000000ff
0 0 0 80000123 00000000 0000007f
0 0 1 80000123 00000000 0000007f
0 1 0 80000120 00000000 fffffedf
0 1 1 80000120 00000000 0000fedf
0 1 0 80000122 00000000 00007fff
1 2 0 00000104 12345678 00000000
0 2 0 00000104 00000000 12345678
1 0 0 00000101 000000ab 00000000
0 2 0 00000100 00000000 ffffabff
1 1 0 0000010a 0000beef 00000000
0 2 0 00000108 00000000 beeffef7
0 1 1 0000010a 00000000 0000beef
0 0 0 00000101 00000000 ffffffab
// two more lines of set 0 force the dirty line out
0 2 0 00000200 00000000 fffffdff
0 2 0 00000300 00000000 fffffcff
0 2 0 00000104 00000000 12345678
0 2 0 00000108 00000000 beeffef7

// File: compile.f
hw/dcache_pkg.sv
hw/dcache_beat_counter.sv
hw/dcache_ctrl_fsm.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_load_align.sv
hw/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/dcache_beat_counter.sv
  - hw/dcache_ctrl_fsm.sv
  - hw/dcache_tag_array.sv
  - hw/dcache_data_array.sv
  - hw/dcache_load_align.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_checker.sv
      - sim/tb_dcache.sv

// File: sim/tb_dcache.sv
// top testbench of the data cache, drives requests from the case file against a bus memory model
`timescale 1ns/10ps
module tb_dcache;
  import dcache_pkg::*;

  logic        clk;
  logic        rst_n;
  dcache_req_t req;
  logic        req_ready;
  dcache_rsp_t rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic [31:0] exp_rdata;

  logic [31:0] case_words [0:511];
  int unsigned n_cases;
  int unsigned err_cnt;
  int unsigned rsp_cnt;
  int unsigned wb_cnt;
  int unsigned tb_errs;
  dcache_req_t next_req;

  logic [31:0] bus_mem [int unsigned];
  logic [31:0] rnd;
  logic [31:0] wr_addr;
  logic [31:0] rd_addr;
  int unsigned wr_beat;
  int unsigned rd_beat;
  logic        rd_active;

  dcache_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .req_ready_o(req_ready),
    .rsp_o      (rsp),
    .mem_o      (mem_req),
    .mem_i      (mem_rsp)
  );

  dcache_checker u_check (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .req_ready_i(req_ready),
    .rsp_i      (rsp),
    .mem_req_i  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .exp_rdata_i(exp_rdata),
    .err_cnt_o  (err_cnt),
    .rsp_cnt_o  (rsp_cnt),
    .wb_cnt_o   (wb_cnt)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] mem_word(logic [31:0] addr);
    if (bus_mem.exists(addr)) begin
      return bus_mem[addr];
    end
    return ~addr;
  endfunction

  // ============================================================
  // bus memory model with random ready and valid timing
  // ============================================================
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_rsp   <= '0;
      rnd       = 32'hbf0e_f63c;
      rd_active = 1'b0;
    end else begin
      if (mem_req.aw_valid && mem_rsp.aw_ready) begin
        wr_addr = mem_req.aw_addr;
        wr_beat = 0;
      end
      if (mem_req.w_valid && mem_rsp.w_ready) begin
        bus_mem[wr_addr + 4 * wr_beat] = mem_req.w_data;
        wr_beat++;
      end
      if (mem_req.ar_valid && mem_rsp.ar_ready) begin
        rd_addr   = mem_req.ar_addr;
        rd_beat   = 0;
        rd_active = 1'b1;
      end
      if (mem_rsp.r_valid && mem_req.r_ready) begin
        rd_beat++;
        if (mem_rsp.r_last) begin
          rd_active = 1'b0;
        end
      end
      rnd = next_random(rnd);
      mem_rsp.aw_ready <= rnd[0];
      mem_rsp.ar_ready <= rnd[1];
      mem_rsp.w_ready  <= rnd[2];
      // a read beat on offer stays until taken
      if (mem_rsp.r_valid && !mem_req.r_ready) begin
        mem_rsp.r_valid <= 1'b1;
      end else if (rd_active && rnd[3]) begin
        mem_rsp.r_valid <= 1'b1;
        mem_rsp.r_data  <= mem_word(rd_addr + 4 * rd_beat);
        mem_rsp.r_last  <= (rd_beat == 3);
      end else begin
        mem_rsp.r_valid <= 1'b0;
      end
    end
  end

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    clk       = 1'b0;
    rst_n     <= 1'b0;
    req       <= '0;
    mem_rsp   <= '0;
    exp_rdata <= '0;
    tb_errs   = 0;
    $readmemh("sim/dcache_cases.txt", case_words);
    n_cases = case_words[0];
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < n_cases; i++) begin
      next_req             = '0;
      next_req.valid       = 1'b1;
      next_req.op          = mem_op_e'(case_words[1 + 6 * i][0]);
      next_req.size        = size_e'(case_words[2 + 6 * i][1:0]);
      next_req.is_unsigned = case_words[3 + 6 * i][0];
      next_req.addr.raw    = case_words[4 + 6 * i];
      next_req.wdata       = case_words[5 + 6 * i];
      req       <= next_req;
      exp_rdata <= case_words[6 + 6 * i];
      @(posedge clk);
      while (!req_ready) begin
        @(posedge clk);
      end
    end
    req <= '0;
    wait (rsp_cnt == n_cases);
    repeat (4) @(posedge clk);
    if (wb_cnt == 0) begin
      $display("no dirty line was ever written back to memory");
      tb_errs++;
    end
    $display("errors: %0d checker, %0d testbench, responses: %0d, writebacks: %0d",
             err_cnt, tb_errs, rsp_cnt, wb_cnt);
    if ((err_cnt == 0) && (tb_errs == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog allows 200 cycles per case
  initial begin
    #1;
    repeat (16 + n_cases * 200) @(posedge clk);
    $display("timeout: the cases did not finish, %0d of %0d responses seen", rsp_cnt, n_cases);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: sim/dcache_checker.sv
// testbench monitor for the data cache, checks responses, bus protocol and writeback data
`timescale 1ns/10ps
module dcache_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::dcache_req_t req_i,
  input  logic                    req_ready_i,
  input  dcache_pkg::dcache_rsp_t rsp_i,
  input  dcache_pkg::mem_req_t    mem_req_i,
  input  dcache_pkg::mem_rsp_t    mem_rsp_i,
  input  logic [31:0]             exp_rdata_i,
  output int unsigned             err_cnt_o,
  output int unsigned             rsp_cnt_o,
  output int unsigned             wb_cnt_o
);
  import dcache_pkg::*;

  logic        exp_load [$];
  logic [31:0] exp_data [$];
  int unsigned exp_cycle [$];
  int unsigned exp_fills [$];
  logic [31:0] ref_mem [int unsigned];

  int unsigned cycle;
  int unsigned fills;
  int unsigned w_beat;
  logic        rd_open;
  int unsigned busy_accepts;
  logic [31:0] wb_addr;
  logic        wb_open;
  mem_req_t    prev_req;
  mem_rsp_t    prev_rsp;

  // expected memory holds the inverse address unless a store changed the word
  function automatic logic [31:0] ref_word(logic [31:0] addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return ~addr;
  endfunction

  task automatic apply_store(dcache_req_t r);
    logic [31:0] a;
    logic [31:0] w;
    a = {r.addr.raw[31:2], 2'b00};
    w = ref_word(a);
    case (r.size)
      SIZE_B:  w[r.addr.raw[1:0]*8 +: 8] = r.wdata[7:0];
      SIZE_H:  w[r.addr.raw[1]*16 +: 16] = r.wdata[15:0];
      default: w = r.wdata;
    endcase
    ref_mem[a] = w;
  endtask

  task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("ERR t=%0t %s got %08h expected %08h", $time, name, got, exp);
    err_cnt_o++;
  endtask

  task automatic fail_text(string msg);
    $display("at %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  initial begin
    err_cnt_o = 0;
    rsp_cnt_o = 0;
    wb_cnt_o  = 0;
    cycle     = 0;
    fills     = 0;
    rd_open   = 1'b0;
    wb_open   = 1'b0;
    prev_req  = '0;
    prev_rsp  = '0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      // ============================================================
      // core side
      // ============================================================
      if (rsp_i.valid) begin
        rsp_cnt_o++;
        if (exp_load.size() == 0) begin
          fail_text("response arrived with no request outstanding");
        end else begin
          if (exp_load[0] && (rsp_i.rdata !== exp_data[0])) begin
            fail_value("rsp_o.rdata", rsp_i.rdata, exp_data[0]);
          end
          // no refill in between means the request hit
          if ((exp_fills[0] == fills) && (cycle - exp_cycle[0] != 3)) begin
            fail_text($sformatf("hit answered %0d cycles after acceptance, not 2",
                                cycle - exp_cycle[0] - 1));
          end
          void'(exp_load.pop_front());
          void'(exp_data.pop_front());
          void'(exp_cycle.pop_front());
          void'(exp_fills.pop_front());
        end
      end
      if (req_i.valid && req_ready_i) begin
        exp_load.push_back(req_i.op == MEM_LOAD);
        exp_data.push_back(exp_rdata_i);
        exp_cycle.push_back(cycle);
        exp_fills.push_back(fills);
        if (req_i.op == MEM_STORE) begin
          apply_store(req_i);
        end
      end
      // at most the one request that fills s1 while a miss runs
      if (mem_req_i.aw_valid || mem_req_i.w_valid || mem_req_i.ar_valid || mem_req_i.r_ready) begin
        if (req_i.valid && req_ready_i) begin
          busy_accepts++;
        end
        if (busy_accepts > 1) begin
          fail_text("req_ready_o stayed high while a miss was outstanding");
        end
      end else begin
        busy_accepts = 0;
      end

      // ============================================================
      // bus side
      // ============================================================
      if (mem_req_i.aw_valid && mem_rsp_i.aw_ready) begin
        if (mem_req_i.aw_addr[3:0] != 4'd0) begin
          fail_text("write burst address is not line aligned");
        end
        wb_addr = mem_req_i.aw_addr;
        w_beat  = 0;
        wb_open = 1'b1;
        wb_cnt_o++;
      end
      if (mem_req_i.w_valid && mem_rsp_i.w_ready) begin
        if (!wb_open) begin
          fail_text("write data beat without a write address");
        end
        if (mem_req_i.w_data !== ref_word(wb_addr + 4 * w_beat)) begin
          fail_value("mem_o.w_data", mem_req_i.w_data, ref_word(wb_addr + 4 * w_beat));
        end
        if (mem_req_i.w_last !== (w_beat == 3)) begin
          fail_value("mem_o.w_last", 32'(mem_req_i.w_last), 32'(w_beat == 3));
        end
        if (mem_req_i.w_last) begin
          wb_open = 1'b0;
        end
        w_beat++;
      end
      if (mem_req_i.ar_valid && wb_open) begin
        fail_text("read address issued before the write burst ended");
      end
      if (mem_req_i.ar_valid && mem_rsp_i.ar_ready) begin
        if (mem_req_i.ar_addr[3:0] != 4'd0) begin
          fail_text("read burst address is not line aligned");
        end
        rd_open = 1'b1;
      end
      if (mem_req_i.r_ready && !rd_open) begin
        fail_text("r_ready raised with no read burst open");
      end
      if (mem_rsp_i.r_valid && mem_req_i.r_ready && mem_rsp_i.r_last) begin
        fills++;
        rd_open = 1'b0;
      end
      if (prev_req.ar_valid && !prev_rsp.ar_ready &&
          (!mem_req_i.ar_valid || (mem_req_i.ar_addr != prev_req.ar_addr))) begin
        fail_text("ar_valid or ar_addr changed before ar_ready");
      end
      if (prev_req.aw_valid && !prev_rsp.aw_ready &&
          (!mem_req_i.aw_valid || (mem_req_i.aw_addr != prev_req.aw_addr))) begin
        fail_text("aw_valid or aw_addr changed before aw_ready");
      end
      if (prev_req.w_valid && !prev_rsp.w_ready &&
          (!mem_req_i.w_valid || (mem_req_i.w_data != prev_req.w_data))) begin
        fail_text("w_valid or w_data changed before w_ready");
      end
      prev_req = mem_req_i;
      prev_rsp = mem_rsp_i;
    end
  end

endmodule

// File: hw/dcache_top.sv
// two-way write-back data cache, core requests on req_i/rsp_o and line bursts on mem_o/mem_i
`timescale 1ns/10ps
module dcache_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::dcache_req_t req_i,
  output logic                    req_ready_o,
  output dcache_pkg::dcache_rsp_t rsp_o,
  output dcache_pkg::mem_req_t    mem_o,
  input  dcache_pkg::mem_rsp_t    mem_i
);
  import dcache_pkg::*;

  dcache_req_t       s1_q;
  dcache_req_t       s2_q;
  logic              s1_ready;
  logic              s2_ready;
  logic              s2_miss;
  logic [WAY_W-1:0]  s2_way;
  logic [TAG_W-1:0]  s2_vtag;
  logic              s2_vdirty;

  logic              hit;
  logic [WAY_W-1:0]  hit_way;
  logic [WAY_W-1:0]  victim_way;
  logic [WAY_W-1:0]  s1_way;
  logic [TAG_W-1:0]  victim_tag;
  logic              victim_dirty;
  logic              s1_vdirty;
  logic [IDX_W-1:0]  tag_rd_idx;
  logic [IDX_W-1:0]  data_rd_idx;
  logic [WAY_W-1:0]  data_rd_way;
  line_t             line;
  logic              s2_store;
  logic              store_hit;
  logic              store_en;
  logic [DATA_W-1:0] load_data;

  logic              aw_valid;
  logic              w_valid;
  logic              ar_valid;
  logic              r_ready;
  logic              beat_en;
  logic              beat_adv;
  logic              fill;
  logic              done;
  logic [BEAT_W-1:0] beat;
  logic              beat_last;

  // ==========================================================
  // stall rule and array addressing
  // ==========================================================
  always_comb begin
    s2_ready    = ~s2_q.valid | ~s2_miss;
    s1_ready    = ~s1_q.valid | s2_ready;
    req_ready_o = s1_ready;
    // a stalled s1 keeps re-reading its set so refills become visible
    tag_rd_idx  = s1_ready ? req_i.addr.f.idx : s1_q.addr.f.idx;
    s1_way      = hit ? hit_way : victim_way;
    s2_store    = s2_q.valid & (s2_q.op == MEM_STORE);
    store_hit   = s2_store & ~s2_miss;
    store_en    = s2_store & (~s2_miss | fill);
    // dirty bit set by the store leaving s2 this cycle
    s1_vdirty   = victim_dirty | (store_hit & (s2_q.addr.f.idx == s1_q.addr.f.idx) &
                                  (s2_way == victim_way));
    data_rd_idx = s2_ready ? s1_q.addr.f.idx : s2_q.addr.f.idx;
    data_rd_way = s2_ready ? s1_way : s2_way;
  end

  // ==========================================================
  // pipeline registers
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_q    <= '0;
      s2_q    <= '0;
      s2_miss <= 1'b0;
      rsp_o   <= '0;
    end else begin
      if (s1_ready) begin
        s1_q <= req_i;
      end
      if (s2_ready) begin
        s2_q    <= s1_q;
        s2_miss <= s1_q.valid & ~hit;
      end else if (done) begin
        // line now present, s2 answers as a hit next cycle
        s2_miss <= 1'b0;
      end
      rsp_o.valid <= s2_q.valid & ~s2_miss;
      rsp_o.rdata <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready) begin
      s2_way    <= s1_way;
      s2_vtag   <= victim_tag;
      s2_vdirty <= s1_vdirty;
    end
  end

  always_comb begin
    mem_o.ar_valid = ar_valid;
    mem_o.ar_addr  = {s2_q.addr.raw[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    mem_o.aw_valid = aw_valid;
    mem_o.aw_addr  = {s2_vtag, s2_q.addr.f.idx, {OFS_W{1'b0}}};
    mem_o.w_valid  = w_valid;
    mem_o.w_data   = line[beat];
    mem_o.w_last   = beat_last;
    mem_o.r_ready  = r_ready;
  end

  dcache_tag_array u_tag (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_idx_i       (tag_rd_idx),
    .lookup_tag_i   (s1_q.addr.f.tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_tag_o   (victim_tag),
    .victim_dirty_o (victim_dirty),
    .touch_i        (s1_q.valid & s2_ready),
    .touch_way_i    (s1_way),
    .install_i      (fill),
    .install_way_i  (s2_way),
    .install_idx_i  (s2_q.addr.f.idx),
    .install_tag_i  (s2_q.addr.f.tag),
    .install_dirty_i(s2_store),
    .mark_dirty_i   (store_hit),
    .mark_way_i     (s2_way),
    .mark_idx_i     (s2_q.addr.f.idx)
  );

  dcache_data_array u_data (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_idx_i    (data_rd_idx),
    .rd_way_i    (data_rd_way),
    .line_o      (line),
    .beat_i      (beat),
    .beat_valid_i(mem_i.r_valid & r_ready),
    .beat_data_i (mem_i.r_data),
    .fill_i      (fill),
    .fill_way_i  (s2_way),
    .fill_idx_i  (s2_q.addr.f.idx),
    .store_i     (store_en),
    .store_way_i (s2_way),
    .store_idx_i (s2_q.addr.f.idx),
    .store_addr_i(s2_q.addr),
    .store_size_i(s2_q.size),
    .store_data_i(s2_q.wdata)
  );

  dcache_ctrl_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (s2_q.valid & s2_miss),
    .victim_dirty_i(s2_vdirty),
    .mem_i         (mem_i),
    .beat_last_i   (beat_last),
    .aw_valid_o    (aw_valid),
    .w_valid_o     (w_valid),
    .ar_valid_o    (ar_valid),
    .r_ready_o     (r_ready),
    .beat_en_o     (beat_en),
    .beat_adv_o    (beat_adv),
    .fill_o        (fill),
    .done_o        (done)
  );

  dcache_beat_counter u_beat (
    .clk   (clk),
    .rst_n (rst_n),
    .en_i  (beat_en),
    .adv_i (beat_adv),
    .beat_o(beat),
    .last_o(beat_last)
  );

  dcache_load_align u_align (
    .line_i       (line),
    .addr_i       (s2_q.addr),
    .size_i       (s2_q.size),
    .is_unsigned_i(s2_q.is_unsigned),
    .rdata_o      (load_data)
  );

endmodule

// File: hw/dcache_load_align.sv
// load data path, selects the addressed word and lane and extends it to 32 bits
`timescale 1ns/10ps
module dcache_load_align (
  input  dcache_pkg::line_t             line_i,
  input  dcache_pkg::dcache_addr_u      addr_i,
  input  dcache_pkg::size_e             size_i,
  input  logic                          is_unsigned_i,
  output logic [dcache_pkg::DATA_W-1:0] rdata_o
);
  import dcache_pkg::*;

  logic [DATA_W-1:0] word;
  logic [7:0]        lane_b;
  logic [15:0]       lane_h;

  always_comb begin
    word   = line_i[addr_i.f.word];
    lane_b = word[{addr_i.f.byte_ofs, 3'b000} +: 8];
    lane_h = word[{addr_i.f.byte_ofs[1], 4'b0000} +: 16];
    case (size_i)
      SIZE_B:  rdata_o = {{24{lane_b[7] & ~is_unsigned_i}}, lane_b};
      SIZE_H:  rdata_o = {{16{lane_h[15] & ~is_unsigned_i}}, lane_h};
      default: rdata_o = word;
    endcase
  end

endmodule

// File: hw/dcache_data_array.sv
// line storage with refill buffer, merges store bytes on a store hit or into a fresh fill
`timescale 1ns/10ps
module dcache_data_array (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [dcache_pkg::IDX_W-1:0]  rd_idx_i,
  input  logic [dcache_pkg::WAY_W-1:0]  rd_way_i,
  output dcache_pkg::line_t             line_o,
  input  logic [dcache_pkg::BEAT_W-1:0] beat_i,
  input  logic                          beat_valid_i,
  input  logic [dcache_pkg::DATA_W-1:0] beat_data_i,
  input  logic                          fill_i,
  input  logic [dcache_pkg::WAY_W-1:0]  fill_way_i,
  input  logic [dcache_pkg::IDX_W-1:0]  fill_idx_i,
  input  logic                          store_i,
  input  logic [dcache_pkg::WAY_W-1:0]  store_way_i,
  input  logic [dcache_pkg::IDX_W-1:0]  store_idx_i,
  input  dcache_pkg::dcache_addr_u      store_addr_i,
  input  dcache_pkg::size_e             store_size_i,
  input  logic [dcache_pkg::DATA_W-1:0] store_data_i
);
  import dcache_pkg::*;

  line_t            data_mem [WAYS][SETS];
  line_t            buf_q;
  line_t            fill_line;
  line_t            wr_line;
  logic             wr_en;
  logic [WAY_W-1:0] wr_way;
  logic [IDX_W-1:0] wr_idx;

  // overlay the store bytes onto one word of the line
  function automatic line_t merge_store(line_t line, dcache_addr_u addr, size_e size,
                                        logic [DATA_W-1:0] data);
    logic [3:0][7:0] word;
    word = line[addr.f.word];
    case (size)
      SIZE_B: word[addr.f.byte_ofs] = data[7:0];
      SIZE_H: begin
        word[{addr.f.byte_ofs[1], 1'b0}] = data[7:0];
        word[{addr.f.byte_ofs[1], 1'b1}] = data[15:8];
      end
      default: word = data;
    endcase
    line[addr.f.word] = word;
    return line;
  endfunction

  always_comb begin
    // final beat is still on the bus when the fill happens
    fill_line = buf_q;
    if (beat_valid_i) begin
      fill_line[beat_i] = beat_data_i;
    end
    wr_en   = fill_i | store_i;
    wr_way  = fill_i ? fill_way_i : store_way_i;
    wr_idx  = fill_i ? fill_idx_i : store_idx_i;
    wr_line = fill_i ? fill_line : data_mem[store_way_i][store_idx_i];
    if (store_i) begin
      wr_line = merge_store(wr_line, store_addr_i, store_size_i, store_data_i);
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid_i) begin
      buf_q[beat_i] <= beat_data_i;
    end
    if (wr_en) begin
      data_mem[wr_way][wr_idx] <= wr_line;
    end
  end

  // write-first read so a reader of the written line sees the new data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_o <= '0;
    end else if (wr_en && (wr_way == rd_way_i) && (wr_idx == rd_idx_i)) begin
      line_o <= wr_line;
    end else begin
      line_o <= data_mem[rd_way_i][rd_idx_i];
    end
  end

endmodule

// File: hw/dcache_tag_array.sv
// tag, valid and dirty storage per way with one replacement bit per set, registered lookup
`timescale 1ns/10ps
module dcache_tag_array (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [dcache_pkg::IDX_W-1:0] rd_idx_i,
  input  logic [dcache_pkg::TAG_W-1:0] lookup_tag_i,
  output logic                         hit_o,
  output logic [dcache_pkg::WAY_W-1:0] hit_way_o,
  output logic [dcache_pkg::WAY_W-1:0] victim_way_o,
  output logic [dcache_pkg::TAG_W-1:0] victim_tag_o,
  output logic                         victim_dirty_o,
  input  logic                         touch_i,
  input  logic [dcache_pkg::WAY_W-1:0] touch_way_i,
  input  logic                         install_i,
  input  logic [dcache_pkg::WAY_W-1:0] install_way_i,
  input  logic [dcache_pkg::IDX_W-1:0] install_idx_i,
  input  logic [dcache_pkg::TAG_W-1:0] install_tag_i,
  input  logic                         install_dirty_i,
  input  logic                         mark_dirty_i,
  input  logic [dcache_pkg::WAY_W-1:0] mark_way_i,
  input  logic [dcache_pkg::IDX_W-1:0] mark_idx_i
);
  import dcache_pkg::*;

  logic [TAG_W-1:0]            tag_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]   valid_q;
  logic [WAYS-1:0][SETS-1:0]   dirty_q;
  logic [SETS-1:0][WAY_W-1:0]  repl_q;

  logic [WAYS-1:0][TAG_W-1:0]  rd_tag;
  logic [WAYS-1:0]             rd_valid;
  logic [WAYS-1:0]             rd_dirty;
  logic [WAY_W-1:0]            rd_repl;
  logic [IDX_W-1:0]            look_idx;
  logic [WAYS-1:0]             inst_fwd;
  logic [WAYS-1:0]             mark_fwd;

  // writes landing on the set being read are passed straight to the read registers
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      inst_fwd[w] = install_i && (install_way_i == WAY_W'(w)) && (install_idx_i == rd_idx_i);
      mark_fwd[w] = mark_dirty_i && (mark_way_i == WAY_W'(w)) && (mark_idx_i == rd_idx_i);
    end
  end

  always_ff @(posedge clk) begin
    look_idx <= rd_idx_i;
    if (install_i) begin
      tag_mem[install_way_i][install_idx_i] <= install_tag_i;
    end
    for (int w = 0; w < WAYS; w++) begin
      rd_tag[w] <= inst_fwd[w] ? install_tag_i : tag_mem[w][rd_idx_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      repl_q   <= '0;
      rd_valid <= '0;
      rd_dirty <= '0;
      rd_repl  <= '0;
    end else begin
      if (install_i) begin
        valid_q[install_way_i][install_idx_i] <= 1'b1;
        dirty_q[install_way_i][install_idx_i] <= install_dirty_i;
      end
      if (mark_dirty_i) begin
        dirty_q[mark_way_i][mark_idx_i] <= 1'b1;
      end
      // the touch belongs to the set of the current lookup
      if (touch_i) begin
        repl_q[look_idx] <= ~touch_way_i;
      end
      for (int w = 0; w < WAYS; w++) begin
        rd_valid[w] <= valid_q[w][rd_idx_i] | inst_fwd[w];
        rd_dirty[w] <= inst_fwd[w] ? install_dirty_i : (dirty_q[w][rd_idx_i] | mark_fwd[w]);
      end
      rd_repl <= (touch_i && (look_idx == rd_idx_i)) ? ~touch_way_i : repl_q[rd_idx_i];
    end
  end

  always_comb begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (rd_valid[w] && (rd_tag[w] == lookup_tag_i)) begin
        hit_o     = 1'b1;
        hit_way_o = WAY_W'(w);
      end
    end
    victim_way_o   = rd_repl;
    victim_tag_o   = rd_tag[rd_repl];
    victim_dirty_o = rd_valid[rd_repl] & rd_dirty[rd_repl];
  end

endmodule

// File: hw/dcache_ctrl_fsm.sv
// miss sequencer of the data cache, runs the dirty writeback burst and then the refill burst
`timescale 1ns/10ps
module dcache_ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 victim_dirty_i,
  input  dcache_pkg::mem_rsp_t mem_i,
  input  logic                 beat_last_i,
  output logic                 aw_valid_o,
  output logic                 w_valid_o,
  output logic                 ar_valid_o,
  output logic                 r_ready_o,
  output logic                 beat_en_o,
  output logic                 beat_adv_o,
  output logic                 fill_o,
  output logic                 done_o
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_MISS,
    S_WRITEBACK,
    S_READ_ADDR,
    S_REFILL
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d    = state_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    r_ready_o  = 1'b0;
    beat_en_o  = 1'b0;
    beat_adv_o = 1'b0;
    fill_o     = 1'b0;
    done_o     = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (start_i) begin
          state_d = S_MISS;
        end
      end
      // dirty victim goes out first, a clean one is simply dropped
      S_MISS: begin
        aw_valid_o = victim_dirty_i;
        ar_valid_o = ~victim_dirty_i;
        if (victim_dirty_i && mem_i.aw_ready) begin
          state_d = S_WRITEBACK;
        end else if (!victim_dirty_i && mem_i.ar_ready) begin
          state_d = S_REFILL;
        end
      end
      S_WRITEBACK: begin
        w_valid_o  = 1'b1;
        beat_en_o  = 1'b1;
        beat_adv_o = mem_i.w_ready;
        if (mem_i.w_ready && beat_last_i) begin
          state_d = S_READ_ADDR;
        end
      end
      S_READ_ADDR: begin
        ar_valid_o = 1'b1;
        if (mem_i.ar_ready) begin
          state_d = S_REFILL;
        end
      end
      S_REFILL: begin
        r_ready_o  = 1'b1;
        beat_en_o  = 1'b1;
        beat_adv_o = mem_i.r_valid;
        // last beat writes the line in the same cycle
        if (mem_i.r_valid && mem_i.r_last) begin
          fill_o  = 1'b1;
          done_o  = 1'b1;
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hw/dcache_beat_counter.sv
// beat index shared by the writeback and refill bursts, with a flag for the final beat
`timescale 1ns/10ps
module dcache_beat_counter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en_i,
  input  logic                          adv_i,
  output logic [dcache_pkg::BEAT_W-1:0] beat_o,
  output logic                          last_o
);
  import dcache_pkg::*;

  // back to zero between bursts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_o <= '0;
    end else if (!en_i) begin
      beat_o <= '0;
    end else if (adv_i) begin
      beat_o <= beat_o + 1'b1;
    end
  end

  assign last_o = (beat_o == BEAT_W'(LINE_WORDS - 1));

endmodule

// File: hw/dcache_pkg.sv
// cache geometry, core request/response types and bus channel types, imported by all cache blocks
package dcache_pkg;

  // ==========================================================
  // geometry
  // ==========================================================
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned WAYS       = 2;
  localparam int unsigned SETS       = 16;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned OFS_W      = 4;
  localparam int unsigned IDX_W      = 4;
  localparam int unsigned TAG_W      = 24;
  localparam int unsigned BEAT_W     = 2;
  localparam int unsigned WAY_W      = $clog2(WAYS);

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } size_e;

  // address fields from the msb down
  typedef struct packed {
    logic [TAG_W-1:0]        tag;
    logic [IDX_W-1:0]        idx;
    logic [BEAT_W-1:0]       word;
    logic [OFS_W-BEAT_W-1:0] byte_ofs;
  } dcache_addr_fields_t;

  // raw word for the bus, fields for lookup and merging
  typedef union packed {
    logic [ADDR_W-1:0]   raw;
    dcache_addr_fields_t f;
  } dcache_addr_u;

  // ==========================================================
  // core side
  // ==========================================================
  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    size_e             size;
    logic              is_unsigned;
    dcache_addr_u      addr;
    logic [DATA_W-1:0] wdata;
  } dcache_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } dcache_rsp_t;

  typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_t;

  // ==========================================================
  // memory bus
  // ==========================================================
  typedef struct packed {
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
    logic              w_last;
    logic              r_ready;
  } mem_req_t;

  typedef struct packed {
    logic              ar_ready;
    logic              aw_ready;
    logic              w_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic              r_last;
  } mem_rsp_t;

endpackage
